// ==== common/rv_exec_cfg.svh ====
// execute stage configuration
// widths of the datapath and the pc step used for link values

`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// pc and branch target width
`define RV_ADDR_BITS 32

// operand, immediate and result width
`define RV_DATA_BITS 32

// architectural register index width
`define RV_REG_BITS 5

// byte distance to the next sequential instruction
`define RV_PC_STEP 4

`endif

// ==== common/rv_exec_pkg.sv ====
// execute stage shared types
// width typedefs, the micro-op encoding and the merge register state

package rv_exec_pkg;

  `include "rv_exec_cfg.svh"

  // ----------------------------------------------------------
  // datapath widths
  // ----------------------------------------------------------

  typedef logic [`RV_ADDR_BITS-1:0] addr_t;
  typedef logic [`RV_DATA_BITS-1:0] data_t;
  typedef logic [`RV_REG_BITS-1:0]  reg_addr_t;

  // ----------------------------------------------------------
  // micro-ops sent by decode
  // ----------------------------------------------------------

  typedef enum logic [4:0] {
    // register and immediate arithmetic
    uop_add,
    uop_sub,
    uop_and,
    uop_or,
    uop_xor,
    uop_slt,
    uop_sltu,
    uop_sll,
    uop_srl,
    uop_sra,
    // op2 already holds the shifted immediate
    uop_lui,
    // conditional branches
    uop_beq,
    uop_bne,
    uop_blt,
    uop_bge,
    uop_bltu,
    uop_bgeu,
    // unconditional jumps, both write the link value
    uop_jal,
    uop_jalr
  } rv_uop;

  // ----------------------------------------------------------
  // writeback register occupancy
  // ----------------------------------------------------------

  typedef enum logic {
    merge_empty,
    merge_full
  } merge_state_t;

endpackage

// ==== logic/dx_pipe_reg.sv ====
// decode to execute input register
// one-entry val/rdy buffer which also drops the wrong-path message after a squash

module dx_pipe_reg (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dx_val,
  output logic                   dx_rdy,
  input  rv_exec_pkg::addr_t     dx_pc,
  input  rv_exec_pkg::data_t     dx_op1,
  input  rv_exec_pkg::data_t     dx_op2,
  input  rv_exec_pkg::data_t     dx_imm,
  input  rv_exec_pkg::reg_addr_t dx_waddr,
  input  rv_exec_pkg::rv_uop     dx_uop,
  input  logic                   x_advance,
  input  logic                   squash,
  output logic                   x_val,
  output rv_exec_pkg::addr_t     x_pc,
  output rv_exec_pkg::data_t     x_op1,
  output rv_exec_pkg::data_t     x_op2,
  output rv_exec_pkg::data_t     x_imm,
  output rv_exec_pkg::reg_addr_t x_waddr,
  output rv_exec_pkg::rv_uop     x_uop
);

  import rv_exec_pkg::*;

  logic      valid_q;
  logic      kill_pending_q;
  logic      accept;
  logic      kill_arrival;
  logic      drain;
  addr_t     pc_q;
  data_t     op1_q;
  data_t     op2_q;
  data_t     imm_q;
  reg_addr_t waddr_q;
  rv_uop     uop_q;

  // ----------------------------------------------------------
  // handshake and kill decisions
  // ----------------------------------------------------------

  // free slot, or the held entry leaves this cycle (moved on or killed)
  assign dx_rdy = !valid_q || x_advance || squash;
  assign accept = dx_val && dx_rdy;

  // an entry held during squash is the younger wrong-path message
  assign drain = valid_q && (x_advance || squash);

  // nothing held to kill, so the next arrival is the one dropped
  assign kill_arrival = accept && !valid_q && (squash || kill_pending_q);

  // killed entry never reaches the merge stage
  assign x_val = valid_q && !squash;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q        <= 1'b0;
      kill_pending_q <= 1'b0;
    end else begin
      if (accept && !kill_arrival) begin
        valid_q <= 1'b1;
      end else if (drain) begin
        valid_q <= 1'b0;
      end
      // one kill per squash, either here or on the next arrival
      if (kill_arrival) begin
        kill_pending_q <= 1'b0;
      end else if (squash && !valid_q) begin
        kill_pending_q <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // message payload
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept && !kill_arrival) begin
      pc_q    <= dx_pc;
      op1_q   <= dx_op1;
      op2_q   <= dx_op2;
      imm_q   <= dx_imm;
      waddr_q <= dx_waddr;
      uop_q   <= dx_uop;
    end
  end

  assign x_pc    = pc_q;
  assign x_op1   = op1_q;
  assign x_op2   = op2_q;
  assign x_imm   = imm_q;
  assign x_waddr = waddr_q;
  assign x_uop   = uop_q;

endmodule

// ==== execute/alu_unit.sv ====
// integer ALU of the execute stage
// combinational result for the arithmetic, logic, compare and shift micro-ops

module alu_unit (
  input  rv_exec_pkg::data_t x_op1,
  input  rv_exec_pkg::data_t x_op2,
  input  rv_exec_pkg::rv_uop x_uop,
  output rv_exec_pkg::data_t alu_result
);

  import rv_exec_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // rv32 shifts use only the low five bits of op2
  assign shamt = x_op2[4:0];

  // compares shared by slt and sltu
  assign lt_signed   = $signed(x_op1) < $signed(x_op2);
  assign lt_unsigned = x_op1 < x_op2;

  // ----------------------------------------------------------
  // result select
  // ----------------------------------------------------------

  always_comb begin
    case (x_uop)
      uop_add: begin
        alu_result = x_op1 + x_op2;
      end
      uop_sub: begin
        alu_result = x_op1 - x_op2;
      end
      uop_and: begin
        alu_result = x_op1 & x_op2;
      end
      uop_or: begin
        alu_result = x_op1 | x_op2;
      end
      uop_xor: begin
        alu_result = x_op1 ^ x_op2;
      end
      // set-less-than gives a zero-extended flag
      uop_slt: begin
        alu_result = data_t'(lt_signed);
      end
      uop_sltu: begin
        alu_result = data_t'(lt_unsigned);
      end
      uop_sll: begin
        alu_result = x_op1 << shamt;
      end
      uop_srl: begin
        alu_result = x_op1 >> shamt;
      end
      // arithmetic shift keeps the sign bit
      uop_sra: begin
        alu_result = data_t'($signed(x_op1) >>> shamt);
      end
      uop_lui: begin
        alu_result = x_op2;
      end
      // branches and jumps, merge takes the link value instead
      default: begin
        alu_result = '0;
      end
    endcase
  end

endmodule

// ==== execute/branch_unit.sv ====
// branch resolution unit
// evaluates branch conditions and forms the target and link for control micro-ops

`include "rv_exec_cfg.svh"

module branch_unit (
  input  rv_exec_pkg::addr_t x_pc,
  input  rv_exec_pkg::data_t x_op1,
  input  rv_exec_pkg::data_t x_op2,
  input  rv_exec_pkg::data_t x_imm,
  input  rv_exec_pkg::rv_uop x_uop,
  output logic               br_is_ctrl,
  output logic               br_taken,
  output rv_exec_pkg::addr_t br_target,
  output rv_exec_pkg::data_t br_link
);

  import rv_exec_pkg::*;

  logic  op_eq;
  logic  op_lt;
  logic  op_ltu;
  addr_t pc_rel;
  addr_t reg_rel;

  // operand compares
  assign op_eq  = x_op1 == x_op2;
  assign op_lt  = $signed(x_op1) < $signed(x_op2);
  assign op_ltu = x_op1 < x_op2;

  // ----------------------------------------------------------
  // target and link
  // ----------------------------------------------------------

  // branches and jal are pc relative
  assign pc_rel = x_pc + addr_t'(x_imm);

  // jalr base register, low bit forced clear below
  assign reg_rel = addr_t'(x_op1 + x_imm);

  assign br_target = (x_uop == uop_jalr) ? (reg_rel & ~addr_t'(1)) : pc_rel;

  // return address written by jumps
  assign br_link = data_t'(x_pc + addr_t'(`RV_PC_STEP));

  // ----------------------------------------------------------
  // taken decision
  // ----------------------------------------------------------

  always_comb begin
    br_is_ctrl = 1'b1;
    case (x_uop)
      uop_beq:  br_taken = op_eq;
      uop_bne:  br_taken = !op_eq;
      uop_blt:  br_taken = op_lt;
      uop_bge:  br_taken = !op_lt;
      uop_bltu: br_taken = op_ltu;
      uop_bgeu: br_taken = !op_ltu;
      // jumps always redirect
      uop_jal:  br_taken = 1'b1;
      uop_jalr: br_taken = 1'b1;
      default: begin
        br_is_ctrl = 1'b0;
        br_taken   = 1'b0;
      end
    endcase
  end

endmodule

// ==== execute/result_merge.sv ====
// result merge and writeback register
// picks the ALU or link result, drives the writeback link and the squash pulse

module result_merge (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   x_val,
  input  rv_exec_pkg::addr_t     x_pc,
  input  rv_exec_pkg::reg_addr_t x_waddr,
  input  rv_exec_pkg::rv_uop     x_uop,
  input  rv_exec_pkg::data_t     alu_result,
  input  logic                   br_is_ctrl,
  input  logic                   br_taken,
  input  rv_exec_pkg::addr_t     br_target,
  input  rv_exec_pkg::data_t     br_link,
  input  logic                   wb_rdy,
  output logic                   x_advance,
  output logic                   wb_val,
  output rv_exec_pkg::addr_t     wb_pc,
  output rv_exec_pkg::reg_addr_t wb_waddr,
  output rv_exec_pkg::data_t     wb_data,
  output logic                   squash,
  output rv_exec_pkg::addr_t     branch_target
);

  import rv_exec_pkg::*;

  merge_state_t state_q;
  logic         load;
  logic         is_jump;
  logic         writes_wb;

  // ----------------------------------------------------------
  // load and drain control
  // ----------------------------------------------------------

  // room now, or the held result leaves on this edge
  assign x_advance = (state_q == merge_empty) || wb_rdy;
  assign load      = x_val && x_advance;

  // plain branches have no destination
  assign is_jump   = (x_uop == uop_jal) || (x_uop == uop_jalr);
  assign writes_wb = !br_is_ctrl || is_jump;

  assign wb_val = (state_q == merge_full);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= merge_empty;
      squash  <= 1'b0;
    end else begin
      // pulse only on the load edge, so a stall never repeats it
      squash <= load && br_is_ctrl && br_taken;
      if (load) begin
        state_q <= writes_wb ? merge_full : merge_empty;
      end else if (wb_rdy) begin
        state_q <= merge_empty;
      end
    end
  end

  // ----------------------------------------------------------
  // writeback payload and redirect target
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load && writes_wb) begin
      wb_pc    <= x_pc;
      wb_waddr <= x_waddr;
      // jumps write pc plus step, everything else the ALU value
      wb_data  <= is_jump ? br_link : alu_result;
    end
    // only looked at while squash is high
    if (load) begin
      branch_target <= br_target;
    end
  end

endmodule

// ==== execute/execute_stage.sv ====
// rv32 execute stage top level
// input register, ALU and branch units side by side, result merge to writeback

module execute_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dx_val,
  output logic                   dx_rdy,
  input  rv_exec_pkg::addr_t     dx_pc,
  input  rv_exec_pkg::data_t     dx_op1,
  input  rv_exec_pkg::data_t     dx_op2,
  input  rv_exec_pkg::data_t     dx_imm,
  input  rv_exec_pkg::reg_addr_t dx_waddr,
  input  rv_exec_pkg::rv_uop     dx_uop,
  output logic                   wb_val,
  input  logic                   wb_rdy,
  output rv_exec_pkg::addr_t     wb_pc,
  output rv_exec_pkg::reg_addr_t wb_waddr,
  output rv_exec_pkg::data_t     wb_data,
  output logic                   squash,
  output rv_exec_pkg::addr_t     branch_target
);

  import rv_exec_pkg::*;

  // held message, fanned out to both units
  logic      x_val;
  addr_t     x_pc;
  data_t     x_op1;
  data_t     x_op2;
  data_t     x_imm;
  reg_addr_t x_waddr;
  rv_uop     x_uop;
  logic      x_advance;

  // unit results
  data_t     alu_result;
  logic      br_is_ctrl;
  logic      br_taken;
  addr_t     br_target;
  data_t     br_link;

  dx_pipe_reg u_dx_pipe_reg (
    .clk       (clk),
    .rst       (rst),
    .dx_val    (dx_val),
    .dx_rdy    (dx_rdy),
    .dx_pc     (dx_pc),
    .dx_op1    (dx_op1),
    .dx_op2    (dx_op2),
    .dx_imm    (dx_imm),
    .dx_waddr  (dx_waddr),
    .dx_uop    (dx_uop),
    .x_advance (x_advance),
    .squash    (squash),
    .x_val     (x_val),
    .x_pc      (x_pc),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_imm     (x_imm),
    .x_waddr   (x_waddr),
    .x_uop     (x_uop)
  );

  alu_unit u_alu_unit (
    .x_op1      (x_op1),
    .x_op2      (x_op2),
    .x_uop      (x_uop),
    .alu_result (alu_result)
  );

  branch_unit u_branch_unit (
    .x_pc       (x_pc),
    .x_op1      (x_op1),
    .x_op2      (x_op2),
    .x_imm      (x_imm),
    .x_uop      (x_uop),
    .br_is_ctrl (br_is_ctrl),
    .br_taken   (br_taken),
    .br_target  (br_target),
    .br_link    (br_link)
  );

  result_merge u_result_merge (
    .clk           (clk),
    .rst           (rst),
    .x_val         (x_val),
    .x_pc          (x_pc),
    .x_waddr       (x_waddr),
    .x_uop         (x_uop),
    .alu_result    (alu_result),
    .br_is_ctrl    (br_is_ctrl),
    .br_taken      (br_taken),
    .br_target     (br_target),
    .br_link       (br_link),
    .wb_rdy        (wb_rdy),
    .x_advance     (x_advance),
    .wb_val        (wb_val),
    .wb_pc         (wb_pc),
    .wb_waddr      (wb_waddr),
    .wb_data       (wb_data),
    .squash        (squash),
    .branch_target (branch_target)
  );

endmodule

// ==== verification/execute_tb.sv ====
// execute stage testbench
// random D->X traffic with writeback stalls, checked against a queue model

`include "rv_exec_cfg.svh"

module execute_tb;

  import rv_exec_pkg::*;

  localparam int timed_msgs  = 200;
  localparam int random_msgs = 1500;
  localparam int total_msgs  = timed_msgs + random_msgs;
  localparam int limit_cycles = total_msgs * 8 + 200;

  logic      clk = 1'b0;
  logic      rst;
  logic      dx_val;
  logic      dx_rdy;
  addr_t     dx_pc;
  data_t     dx_op1;
  data_t     dx_op2;
  data_t     dx_imm;
  reg_addr_t dx_waddr;
  rv_uop     dx_uop;
  logic      wb_val;
  logic      wb_rdy = 1'b0;
  addr_t     wb_pc;
  reg_addr_t wb_waddr;
  data_t     wb_data;
  logic      squash;
  addr_t     branch_target;

  // stall mode, latency phase, accept seen before the next edge, wrong-path flag
  logic        random_stall = 1'b0;
  logic        timed_phase = 1'b0;
  logic        will_accept = 1'b0;
  logic        kill_next = 1'b0;
  int          edge_cnt = 0;
  int          wb_errors = 0;
  int          sq_errors = 0;
  int          lat_errors = 0;
  int          proto_errors = 0;

  // expected writebacks and squashes, oldest first
  addr_t     exp_wb_pc[$];
  reg_addr_t exp_wb_waddr[$];
  data_t     exp_wb_data[$];
  int        exp_wb_edge[$];
  logic      exp_wb_timed[$];
  addr_t     exp_sq_target[$];
  int        exp_sq_edge[$];
  logic      exp_sq_timed[$];

  execute_stage DUT (
    .clk           (clk),
    .rst           (rst),
    .dx_val        (dx_val),
    .dx_rdy        (dx_rdy),
    .dx_pc         (dx_pc),
    .dx_op1        (dx_op1),
    .dx_op2        (dx_op2),
    .dx_imm        (dx_imm),
    .dx_waddr      (dx_waddr),
    .dx_uop        (dx_uop),
    .wb_val        (wb_val),
    .wb_rdy        (wb_rdy),
    .wb_pc         (wb_pc),
    .wb_waddr      (wb_waddr),
    .wb_data       (wb_data),
    .squash        (squash),
    .branch_target (branch_target)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // writeback ready, about one stall cycle in four when enabled
  always @(posedge clk) begin
    if (random_stall) begin
      wb_rdy <= ($urandom_range(3, 0) != 0);
    end else begin
      wb_rdy <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // signed compare from the sign bits, then magnitude
  function automatic logic signed_less(data_t a, data_t b);
    if (a[`RV_DATA_BITS-1] != b[`RV_DATA_BITS-1]) begin
      return a[`RV_DATA_BITS-1];
    end
    return a < b;
  endfunction

  function automatic data_t model_alu(rv_uop uop, data_t a, data_t b);
    logic [4:0] sh;
    data_t      ones;
    sh = b[4:0];
    ones = '1;
    case (uop)
      uop_add:  return a + b;
      uop_sub:  return a - b;
      uop_and:  return a & b;
      uop_or:   return a | b;
      uop_xor:  return a ^ b;
      uop_slt:  return data_t'(signed_less(a, b));
      uop_sltu: return data_t'(a < b);
      uop_sll:  return a << sh;
      uop_srl:  return a >> sh;
      // logical shift, then fill the vacated top bits with the sign
      uop_sra:  return (a >> sh) | (a[`RV_DATA_BITS-1] ? ~(ones >> sh) : '0);
      uop_lui:  return b;
      default:  return '0;
    endcase
  endfunction

  function automatic logic model_taken(rv_uop uop, data_t a, data_t b);
    case (uop)
      uop_beq:  return a == b;
      uop_bne:  return a != b;
      uop_blt:  return signed_less(a, b);
      uop_bge:  return !signed_less(a, b);
      uop_bltu: return a < b;
      uop_bgeu: return a >= b;
      uop_jal:  return 1'b1;
      uop_jalr: return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  // one accepted message, in D->X order
  task automatic model_accept();
    logic is_ctrl;
    logic is_jump;
    addr_t tgt;
    is_ctrl = dx_uop inside {uop_beq, uop_bne, uop_blt, uop_bge, uop_bltu, uop_bgeu,
                             uop_jal, uop_jalr};
    is_jump = dx_uop inside {uop_jal, uop_jalr};
    // wrong-path message after a taken transfer
    if (kill_next) begin
      kill_next = 1'b0;
      return;
    end
    if (!is_ctrl || is_jump) begin
      exp_wb_pc.push_back(dx_pc);
      exp_wb_waddr.push_back(dx_waddr);
      exp_wb_data.push_back(is_jump ? data_t'(dx_pc + `RV_PC_STEP)
                                    : model_alu(dx_uop, dx_op1, dx_op2));
      exp_wb_edge.push_back(edge_cnt + 1);
      exp_wb_timed.push_back(timed_phase);
    end
    if (model_taken(dx_uop, dx_op1, dx_op2)) begin
      tgt = (dx_uop == uop_jalr) ? ((dx_op1 + dx_imm) & ~addr_t'(1)) : (dx_pc + dx_imm);
      exp_sq_target.push_back(tgt);
      exp_sq_edge.push_back(edge_cnt + 1);
      exp_sq_timed.push_back(timed_phase);
      kill_next = 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  // result must show up one edge after its accept
  task automatic check_latency(int acc_edge, string kind);
    if (edge_cnt != acc_edge + 1) begin
      $display("Error @%0t: %s at edge %0d, expected edge %0d", $time, kind, edge_cnt,
               acc_edge + 1);
      lat_errors++;
    end
  endtask

  task automatic check_wb(addr_t pc, reg_addr_t waddr, data_t data);
    addr_t     e_pc;
    reg_addr_t e_waddr;
    data_t     e_data;
    int        e_edge;
    logic      e_timed;
    if (exp_wb_pc.size() == 0) begin
      $display("writeback at time %0t while no result was outstanding", $time);
      proto_errors++;
      return;
    end
    e_pc = exp_wb_pc.pop_front();
    e_waddr = exp_wb_waddr.pop_front();
    e_data = exp_wb_data.pop_front();
    e_edge = exp_wb_edge.pop_front();
    e_timed = exp_wb_timed.pop_front();
    if (pc !== e_pc || waddr !== e_waddr || data !== e_data) begin
      $display("Error @%0t: writeback pc %h rd %0d data %h, expected pc %h rd %0d data %h",
               $time, pc, waddr, data, e_pc, e_waddr, e_data);
      wb_errors++;
    end
    if (e_timed) begin
      check_latency(e_edge, "writeback");
    end
  endtask

  task automatic check_squash(addr_t target);
    addr_t e_target;
    int    e_edge;
    logic  e_timed;
    if (exp_sq_target.size() == 0) begin
      $display("squash at time %0t while no taken transfer was outstanding", $time);
      proto_errors++;
      return;
    end
    e_target = exp_sq_target.pop_front();
    e_edge = exp_sq_edge.pop_front();
    e_timed = exp_sq_timed.pop_front();
    if (target !== e_target) begin
      $display("Error @%0t: squash target %h, expected %h", $time, target, e_target);
      sq_errors++;
    end
    if (e_timed) begin
      check_latency(e_edge, "squash");
    end
  endtask

  // ------------------------------------------------------------
  // monitor, half a cycle after the drive edge
  // ------------------------------------------------------------

  always @(negedge clk) begin
    will_accept = !rst && dx_val && dx_rdy;
    if (will_accept) begin
      model_accept();
    end
    if (!rst && wb_val && wb_rdy) begin
      check_wb(wb_pc, wb_waddr, wb_data);
    end
    if (!rst && squash) begin
      check_squash(branch_target);
    end
  end

  // drive one random message and wait for its accept
  task automatic send_msg(int gap);
    data_t op1;
    op1 = $urandom;
    if (gap > 0) begin
      dx_val <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    dx_val   <= 1'b1;
    dx_pc    <= addr_t'($urandom) & ~addr_t'(3);
    dx_op1   <= op1;
    // equal operands now and then, so beq and bge see both outcomes
    dx_op2   <= ($urandom_range(3, 0) == 0) ? op1 : data_t'($urandom);
    dx_imm   <= $urandom;
    dx_waddr <= reg_addr_t'($urandom_range(31, 0));
    dx_uop   <= rv_uop'($urandom_range(18, 0));
    @(posedge clk);
    while (!will_accept) begin
      @(posedge clk);
    end
  endtask

  initial begin : stimulus
    int total;
    void'($urandom(32'hf2458b0f));
    rst = 1'b1;
    dx_val = 1'b0;
    dx_pc = '0;
    dx_op1 = '0;
    dx_op2 = '0;
    dx_imm = '0;
    dx_waddr = '0;
    dx_uop = uop_add;
    repeat (9) @(posedge clk);
    @(negedge clk);
    if (dx_rdy !== 1'b1 || wb_val !== 1'b0 || squash !== 1'b0) begin
      $display("Error @%0t: in reset dx_rdy %b wb_val %b squash %b, expected 1 0 0",
               $time, dx_rdy, wb_val, squash);
      proto_errors++;
    end
    @(posedge clk);
    rst <= 1'b0;
    // back to back traffic, no stalls, fixed latency
    timed_phase = 1'b1;
    for (int i = 0; i < timed_msgs; i++) begin
      send_msg(0);
    end
    timed_phase = 1'b0;
    // last timed result leaves with wb_rdy still high
    dx_val <= 1'b0;
    @(posedge clk);
    random_stall <= 1'b1;
    for (int i = 0; i < random_msgs; i++) begin
      send_msg($urandom_range(3, 0));
    end
    dx_val <= 1'b0;
    random_stall <= 1'b0;
    while (exp_wb_pc.size() != 0 || exp_sq_target.size() != 0) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);
    total = wb_errors + sq_errors + lat_errors + proto_errors;
    $display("errors: writeback %0d, squash %0d, latency %0d, protocol %0d", wb_errors,
             sq_errors, lat_errors, proto_errors);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, results still outstanding", limit_cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== rv_exec.f ====
+incdir+common
common/rv_exec_pkg.sv
logic/dx_pipe_reg.sv
execute/alu_unit.sv
execute/branch_unit.sv
execute/result_merge.sv
execute/execute_stage.sv
verification/execute_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f rv_exec.f \
  --top-module execute_tb \
  -o execute_sim

# the log decides pass or fail
./obj_dir/execute_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
